// ==== dv/ospfb_chk.sv ====
module ospfb_chk (
  input logic                    clk,
  input logic                    rst,
  input logic                    in_ready,
  input logic                    out_valid,
  input ospfb_sample_pkg::cplx_t out_data
);

  // quiet once reset has been seen on two edges in a row
  a_rst_quiet: assert property (@(posedge clk) rst && $past(rst) |-> !in_ready && !out_valid)
    else $error("in_ready or out_valid high while in reset");

  a_data_known: assert property (@(posedge clk) out_valid |-> !$isunknown(out_data))
    else $error("out_data unknown while out_valid is high");

  // commutator still waiting right after reset
  a_no_early_ready: assert property (@(posedge clk) $fell(rst) |-> !in_ready)
    else $error("in_ready high in the cycle after reset fell");

endmodule

// ==== dv/ospfb_tb.sv ====
`include "ospfb_macros.svh"

module ospfb_tb;

  import ospfb_sample_pkg::*;

  localparam int FFT = `OSPFB_FFT_LEN;
  localparam int DEC = `OSPFB_DEC_FAC;

  logic  clk;
  logic  rst;
  logic  in_valid;
  cplx_t in_data;
  logic  in_ready;
  logic  out_valid;
  cplx_t out_data;
  logic  credit_return;
  cplx_t samples[$];    // accepted inputs in order
  int    due[$];        // cycle after which each held credit goes back
  int    cyc;
  int    errors;
  int    acc_cnt;
  int    out_cnt;
  int    ret_cnt;
  int    frame_acc;     // accepted count at the previous frame end
  int    gen_idx;       // samples offered so far
  bit    timed_out;

  ospfb_top dut0 (.*);

  bind ospfb_top ospfb_chk chk0 (.clk(clk), .rst(rst), .in_ready(in_ready),
    .out_valid(out_valid), .out_data(out_data));

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic int tap_weight(input int p, input int b);
    return (p * FFT + b) % 7 - 3;   // spread over -3..3
  endfunction

  // frame m/FFT, position m%FFT, taken from the rotated branch
  function automatic cplx_t model_out(input int m);
    int k, b, idx, re, im;
    logic signed [15:0] pr, pi;
    cplx_t s;
    k  = m / FFT;
    b  = (m % FFT + k * DEC) % FFT;
    re = 0;
    im = 0;
    for (int p = 0; p < `OSPFB_PTAPS; p++) begin
      idx = k * DEC + DEC - 1 - b - p * FFT;
      if (idx >= 0) begin             // inputs before the first count as zero
        s  = samples[idx];
        pr = s[15:0];
        pi = s[31:16];
        re += tap_weight(p, b) * pr;
        im += tap_weight(p, b) * pi;
      end
    end
    return {im[15:0], re[15:0]};      // wraps at the part width
  endfunction

  task automatic check_out(input int max_delay);
    cplx_t exp_v;
    if (out_cnt + 1 - ret_cnt > `OSPFB_CREDIT_MAX) begin
      errors++;
      $display("output %0d was sent without a credit", out_cnt);
    end
    if (out_cnt == 0 && acc_cnt < `OSPFB_PTAPS * DEC) begin
      errors++;
      $display("first output came after only %0d inputs", acc_cnt);
    end
    if ((out_cnt / FFT + 1) * DEC > samples.size()) begin
      errors++;
      $display("output %0d came before its inputs were accepted", out_cnt);
    end else begin
      exp_v = model_out(out_cnt);
      if (out_data !== exp_v) begin
        errors++;
        $display("CHECK FAILED out_data[%0d] got %h expected %h", out_cnt, out_data, exp_v);
      end
    end
    out_cnt++;
    if (out_cnt % FFT == 0) begin     // frame complete
      if (out_cnt > FFT && acc_cnt - frame_acc != DEC) begin
        errors++;
        $display("frame %0d took %0d new inputs instead of %0d",
                 out_cnt / FFT - 1, acc_cnt - frame_acc, DEC);
      end
      frame_acc = acc_cnt;
    end
    due.push_back(cyc + int'($urandom % (max_delay + 1)));   // sink frees it later
  endtask

  // one clock: observe at the falling edge, drive after the rising edge
  task automatic step(input int gap_pct, input int max_delay, input bit impulse,
                      input bit stop);
    bit taken;
    bit nv;
    int k;
    @(negedge clk);
    if (out_valid) check_out(max_delay);
    if (credit_return) ret_cnt++;
    taken = in_valid && in_ready;     // accepted at the coming edge
    if (taken) begin
      samples.push_back(in_data);
      acc_cnt++;
    end
    @(posedge clk);
    cyc++;
    k = 0;
    while (k < due.size() && due[k] >= cyc) k++;
    credit_return <= (k < due.size());
    if (k < due.size()) due.delete(k);
    if (!in_valid || taken) begin     // an offered sample is held until taken
      nv = !stop && ($urandom % 100 >= gap_pct);
      in_valid <= nv;
      if (nv) begin
        in_data <= !impulse ? $urandom : ((gen_idx == 3) ? 32'h0002_0100 : 32'h0);
        gen_idx++;
      end
    end
  endtask

  task automatic run_test(input int frames, input int gap_pct, input int max_delay,
                          input bit impulse);
    int wait_cyc;
    int quiet;
    int last;
    @(posedge clk);
    rst           <= 1'b1;
    in_valid      <= 1'b0;
    credit_return <= 1'b0;
    samples.delete();
    due.delete();
    acc_cnt   = 0;
    out_cnt   = 0;
    ret_cnt   = 0;
    frame_acc = 0;
    gen_idx   = 0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    repeat (4) begin                  // nothing moves before the first sample
      @(negedge clk);
      if (in_ready || out_valid) begin
        errors++;
        $display("in_ready or out_valid went high before any input");
      end
    end
    wait_cyc = 0;
    while (out_cnt < frames * FFT && !timed_out) begin
      step(gap_pct, max_delay, impulse, 1'b0);
      wait_cyc++;
      if (wait_cyc > 20000) begin
        timed_out = 1'b1;
        $display("timeout: only %0d of %0d outputs arrived", out_cnt, frames * FFT);
      end
    end
    quiet    = 0;
    wait_cyc = 0;
    while ((due.size() > 0 || quiet < 20) && !timed_out) begin   // drain credits
      last = out_cnt;
      step(gap_pct, max_delay, impulse, 1'b1);
      quiet = (out_cnt == last) ? quiet + 1 : 0;
      wait_cyc++;
      if (wait_cyc > 500) begin
        timed_out = 1'b1;
        $display("timeout: output did not settle after the input stopped");
      end
    end
  endtask

  initial begin
    rst           = 1'b1;
    in_valid      = 1'b0;
    in_data       = '0;
    credit_return = 1'b0;
    errors        = 0;
    cyc           = 0;
    timed_out     = 1'b0;
    void'($urandom(32'hd79e));
    run_test(13, 0, 0, 1'b0);                      // steady stream, credits back at once
    if (!timed_out) run_test(13, 40, 0, 1'b0);     // gaps in in_valid
    if (!timed_out) run_test(13, 30, 5, 1'b0);     // slow credit return
    if (!timed_out) run_test(8, 20, 5, 1'b1);      // single impulse
    $display("errors: %0d  timeouts: %0d", errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== hdl/ospfb_credit_out.sv ====
`include "ospfb_macros.svh"

module ospfb_credit_out (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    adv,
  input  logic                    vin,
  input  ospfb_sample_pkg::cplx_t din,
  input  logic                    credit_return,
  output logic                    credit_ok,
  output logic                    out_valid,
  output ospfb_sample_pkg::cplx_t out_data
);

  import ospfb_ctrl_pkg::*;

  credit_t credits;   // free slots at the sink
  logic    take;      // item loaded into the output register

  assign take      = adv & vin;
  assign credit_ok = (credits != '0);

  // charged when the item is loaded, a cycle before out_valid shows it
  always_ff @(posedge clk) begin
    if (rst) begin
      credits   <= credit_t'(`OSPFB_CREDIT_MAX);
      out_valid <= 1'b0;
    end else begin
      out_valid <= take;
      case ({take, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;     // none, or one out and one back
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out_data <= din;
    end
  end

endmodule

// ==== hdl/ospfb_ctrl_pkg.sv ====
`include "ospfb_macros.svh"

package ospfb_ctrl_pkg;

  typedef logic [$clog2(`OSPFB_FFT_LEN)-1:0] phase_t;         // decimation phase / branch
  typedef logic [$clog2(`OSPFB_CREDIT_MAX+1)-1:0] credit_t;   // 0..CREDIT_MAX

  typedef enum logic [1:0] {
    ST_WAIT,      // pipeline flushed, waiting for first sample
    ST_FORWARD,   // phases that take a new input
    ST_FEEDBACK   // phases that reuse the loop buffers
  } comm_state_t;

endpackage

// ==== hdl/ospfb_delay_line.sv ====
module ospfb_delay_line #(
  parameter int DEPTH = 2,
  parameter int WIDTH = 1
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             adv,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout
);

  logic [WIDTH-1:0] taps [DEPTH];   // taps[0] is the newest entry

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        taps[i] <= '0;                // flush so early frames sum to zero
      end
    end else if (adv) begin
      taps[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        taps[i] <= taps[i-1];
      end
    end
  end

  assign dout = taps[DEPTH-1];      // value from DEPTH advances ago

endmodule

// ==== hdl/ospfb_macros.svh ====
`ifndef OSPFB_MACROS_SVH
`define OSPFB_MACROS_SVH

// filter bank geometry
`define OSPFB_FFT_LEN 8      // branches per frame
`define OSPFB_DEC_FAC 6      // new samples per frame
`define OSPFB_PTAPS 4        // processing elements in the chain

// datapath widths
`define OSPFB_SAMPLE_W 16    // one part of a complex sample
`define OSPFB_COEFF_W 4      // signed tap coefficient

// output flow control
`define OSPFB_CREDIT_MAX 4   // credits held after reset

`endif

// ==== hdl/ospfb_pe.sv ====
`include "ospfb_macros.svh"

module ospfb_pe #(
  parameter int TAP = 0
) (
  input  logic                    clk,
  input  logic                    pipe_rst,
  input  logic                    adv,
  input  logic                    vin,
  input  ospfb_sample_pkg::cplx_t din,
  input  ospfb_sample_pkg::cplx_t sin,
  output logic                    vout,
  output ospfb_sample_pkg::cplx_t dout,
  output ospfb_sample_pkg::cplx_t sout
);

  import ospfb_sample_pkg::*;
  import ospfb_ctrl_pkg::*;

  localparam int SW       = `OSPFB_SAMPLE_W;
  localparam int CW       = 2 * `OSPFB_SAMPLE_W;
  localparam int LOOP_LEN = `OSPFB_FFT_LEN - `OSPFB_DEC_FAC;   // samples reused per frame

  phase_t coef_ctr;   // branch served this slot
  coeff_t h;
  cplx_t  a;          // sample into the mac
  cplx_t  loop_q;
  cplx_t  mac;
  part_t  a_re;
  part_t  a_im;
  part_t  s_re;
  part_t  s_im;
  part_t  mac_re;
  part_t  mac_im;

  // branches run downward, the first accepted sample lands in branch DEC_FAC-1
  always_ff @(posedge clk) begin
    if (pipe_rst) begin
      coef_ctr <= phase_t'(`OSPFB_DEC_FAC - 1);
    end else if (adv) begin
      coef_ctr <= coef_ctr - 1'b1;
    end
  end

  assign h = coeff_of(TAP, int'(coef_ctr));

  assign a = vin ? din : loop_q;    // new sample or the one from LOOP_LEN slots back

  assign a_re = part_t'(a[SW-1:0]);
  assign a_im = part_t'(a[CW-1:SW]);
  assign s_re = part_t'(sin[SW-1:0]);
  assign s_im = part_t'(sin[CW-1:SW]);

  assign mac_re = s_re + a_re * h;  // wraps at the part width
  assign mac_im = s_im + a_im * h;
  assign mac    = {mac_im, mac_re};

  ospfb_delay_line #(.DEPTH(LOOP_LEN), .WIDTH(CW)) loop_buf (
    .clk(clk), .rst(pipe_rst), .adv(adv), .din(a), .dout(loop_q)
  );

  // two frames later the next tap needs this sample
  ospfb_delay_line #(.DEPTH(2*`OSPFB_FFT_LEN), .WIDTH(CW)) data_buf (
    .clk(clk), .rst(pipe_rst), .adv(adv), .din(loop_q), .dout(dout)
  );

  ospfb_delay_line #(.DEPTH(`OSPFB_FFT_LEN), .WIDTH(CW)) sum_buf (
    .clk(clk), .rst(pipe_rst), .adv(adv), .din(mac), .dout(sout)
  );

  ospfb_delay_line #(.DEPTH(`OSPFB_FFT_LEN), .WIDTH(1)) valid_buf (
    .clk(clk), .rst(pipe_rst), .adv(adv), .din(vin), .dout(vout)
  );

endmodule

// ==== hdl/ospfb_phase_comp.sv ====
`include "ospfb_macros.svh"

module ospfb_phase_comp (
  input  logic                    clk,
  input  logic                    pipe_rst,
  input  logic                    adv,
  input  logic                    vin,
  input  ospfb_sample_pkg::cplx_t din,
  output logic                    vout,
  output ospfb_sample_pkg::cplx_t dout
);

  import ospfb_sample_pkg::*;
  import ospfb_ctrl_pkg::*;

  localparam phase_t LAST_BR = phase_t'(`OSPFB_FFT_LEN - 1);
  localparam phase_t ROT_STEP = phase_t'(`OSPFB_DEC_FAC);

  cplx_t  mem [2*`OSPFB_FFT_LEN];   // two frame halves
  phase_t wr_br;                    // branch arriving from the last tap
  phase_t rd_pos;                   // output position within the frame
  phase_t rd_br;                    // rotated branch to read
  phase_t rot;                      // rotation of the frame being read
  logic   wr_sel;                   // half being written
  logic   acc_v;                    // frame being written holds real data
  logic   rd_v;                     // frame being read holds real data

  assign rd_pos = LAST_BR - wr_br;  // position steps up as branches step down
  assign rd_br  = rd_pos + rot;     // wraps at FFT_LEN

  always_ff @(posedge clk) begin
    if (pipe_rst) begin
      wr_br  <= phase_t'(`OSPFB_DEC_FAC - 1);  // same branch order as the taps
      wr_sel <= 1'b0;
      acc_v  <= 1'b0;
      rd_v   <= 1'b0;
      rot    <= '0;
    end else if (adv) begin
      wr_br <= (wr_br == '0) ? LAST_BR : wr_br - 1'b1;
      if (wr_br == '0) begin
        wr_sel <= ~wr_sel;              // swap halves at frame end
        rd_v   <= acc_v | vin;
        acc_v  <= 1'b0;
        if (rd_v) begin
          rot <= rot + ROT_STEP;        // next frame shifts by DEC_FAC
        end
      end else begin
        acc_v <= acc_v | vin;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (adv) begin
      mem[{wr_sel, wr_br}] <= din;      // stored by branch
    end
  end

  assign dout = mem[{~wr_sel, rd_br}];
  assign vout = rd_v;

endmodule

// ==== hdl/ospfb_phase_ctrl.sv ====
`include "ospfb_macros.svh"

module ospfb_phase_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic in_valid,
  input  logic credit_ok,
  output logic in_ready,
  output logic adv,
  output logic fresh,
  output logic pipe_rst
);

  import ospfb_ctrl_pkg::*;

  localparam phase_t LAST_PH  = phase_t'(`OSPFB_FFT_LEN - 1);   // wrap point
  localparam phase_t FIRST_FB = phase_t'(`OSPFB_DEC_FAC);       // first feedback phase

  comm_state_t state;
  comm_state_t state_nxt;
  phase_t      phase;       // commutator position
  phase_t      phase_nxt;
  logic        fwd;
  logic        fb;

  assign fwd = (state == ST_FORWARD);
  assign fb  = (state == ST_FEEDBACK);

  // forward slots need a sample, feedback slots only need room downstream
  assign adv      = credit_ok & ((fwd & in_valid) | fb);
  assign in_ready = fwd & credit_ok;
  assign fresh    = adv & fwd;                  // sample taken this slot
  assign pipe_rst = (state == ST_WAIT);         // also true through reset

  assign phase_nxt = (phase == LAST_PH) ? '0 : phase + 1'b1;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_WAIT: begin
        if (in_valid) begin
          state_nxt = ST_FORWARD;               // phase 0 is forward
        end
      end
      default: begin
        if (adv) begin
          state_nxt = (phase_nxt < FIRST_FB) ? ST_FORWARD : ST_FEEDBACK;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_WAIT;
      phase <= '0;
    end else begin
      state <= state_nxt;
      if (adv) begin
        phase <= phase_nxt;                     // held while stalled
      end
    end
  end

endmodule

// ==== hdl/ospfb_sample_pkg.sv ====
`include "ospfb_macros.svh"

package ospfb_sample_pkg;

  typedef logic signed [`OSPFB_SAMPLE_W-1:0] part_t;   // one signed part
  typedef logic [2*`OSPFB_SAMPLE_W-1:0] cplx_t;        // {imag, real}
  typedef logic signed [`OSPFB_COEFF_W-1:0] coeff_t;   // tap weight

  // coefficient for a tap and branch, spread over -3..3
  function automatic coeff_t coeff_of(
    input int tap,
    input int branch
  );
    int idx;
    idx = (tap * `OSPFB_FFT_LEN + branch) % 7;
    return coeff_t'(idx - 3);
  endfunction

endpackage

// ==== hdl/ospfb_top.sv ====
`include "ospfb_macros.svh"

module ospfb_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  input  ospfb_sample_pkg::cplx_t in_data,
  output logic                    in_ready,
  output logic                    out_valid,
  output ospfb_sample_pkg::cplx_t out_data,
  input  logic                    credit_return
);

  import ospfb_sample_pkg::*;

  logic                     credit_ok;
  logic                     adv;        // single advance for every stage
  logic                     fresh;
  logic                     pipe_rst;
  logic [`OSPFB_PTAPS:0]    v_chain;    // valid between taps
  cplx_t [`OSPFB_PTAPS:0]   d_chain;    // samples between taps
  cplx_t [`OSPFB_PTAPS:0]   s_chain;    // partial sums between taps
  logic                     pc_valid;
  cplx_t                    pc_data;

  ospfb_phase_ctrl phase_ctrl0 (
    .clk(clk), .rst(rst), .in_valid(in_valid), .credit_ok(credit_ok),
    .in_ready(in_ready), .adv(adv), .fresh(fresh), .pipe_rst(pipe_rst)
  );

  assign v_chain[0] = fresh;
  assign d_chain[0] = in_data;
  assign s_chain[0] = '0;        // chain starts from an empty sum

  for (genvar i = 0; i < `OSPFB_PTAPS; i++) begin : g_tap
    ospfb_pe #(.TAP(i)) pe (
      .clk(clk), .pipe_rst(pipe_rst), .adv(adv),
      .vin(v_chain[i]), .din(d_chain[i]), .sin(s_chain[i]),
      .vout(v_chain[i+1]), .dout(d_chain[i+1]), .sout(s_chain[i+1])
    );
  end

  // last tap sum carries the full branch result
  ospfb_phase_comp phase_comp0 (
    .clk(clk), .pipe_rst(pipe_rst), .adv(adv),
    .vin(v_chain[`OSPFB_PTAPS]), .din(s_chain[`OSPFB_PTAPS]),
    .vout(pc_valid), .dout(pc_data)
  );

  ospfb_credit_out credit_out0 (
    .clk(clk), .rst(rst), .adv(adv), .vin(pc_valid), .din(pc_data),
    .credit_return(credit_return), .credit_ok(credit_ok),
    .out_valid(out_valid), .out_data(out_data)
  );

endmodule

// ==== ospfb.f ====
+incdir+hdl
hdl/ospfb_sample_pkg.sv
hdl/ospfb_ctrl_pkg.sv
hdl/ospfb_delay_line.sv
hdl/ospfb_phase_ctrl.sv
hdl/ospfb_pe.sv
hdl/ospfb_phase_comp.sv
hdl/ospfb_credit_out.sv
hdl/ospfb_top.sv
dv/ospfb_chk.sv
dv/ospfb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run the testbench, judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module ospfb_tb -f ospfb.f \
  -o ospfb_sim > build.log 2>&1 \
  && ./obj_dir/ospfb_sim > sim.log 2>&1 \
  || echo "build or simulation exited with an error"
grep -qx "sim passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
